/* design/rf_pkg.sv */
// Sizes, entry type, request structs and power states shared by all blocks of the queue
`default_nettype none

package rf_pkg;

    // ------------------------------------------------------------
    // Register file geometry
    // ------------------------------------------------------------

    // Entries held by the register file
    localparam int RF_DEPTH  = 4;
    // Address width that covers RF_DEPTH entries
    localparam int RF_ADDR_W = 2;
    // Width of one stored entry
    localparam int RF_DATA_W = 26;

    // One queue entry as it is stored in the array
    typedef logic [RF_DATA_W-1:0] rf_data_t;

    // ------------------------------------------------------------
    // Register file request buses
    // ------------------------------------------------------------

    // One write request, taken on the rising edge while en is high
    typedef struct packed {
        logic                 en;
        logic [RF_ADDR_W-1:0] addr;
        rf_data_t             data;
    } rf_wr_t;

    // One read request, data returns on the following cycle
    typedef struct packed {
        logic                 en;
        logic [RF_ADDR_W-1:0] addr;
    } rf_rd_t;

    // Power sequence of the array, ON is the only state that accepts pushes
    typedef enum logic [1:0] {
        PWR_ON      = 2'd0,
        PWR_ISOLATE = 2'd1,
        PWR_OFF     = 2'd2,
        PWR_WAKE    = 2'd3
    } pwr_state_t;

endpackage

`default_nettype wire

/* design/rf_array_4x26.sv */
// Behavioral 4x26 storage array with one write port and a registered read port, used by the wrapper
`timescale 1ns/1ps
`default_nettype none

module rf_array_4x26 (
     input  logic             clk
    ,input  logic             rst
    ,input  rf_pkg::rf_wr_t   wr
    ,input  rf_pkg::rf_rd_t   rd
    ,input  logic             powered
    ,output rf_pkg::rf_data_t rdata
);

    import rf_pkg::*;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    // Four entries, addressed directly by the request address
    rf_data_t mem [RF_DEPTH];

    // Registered read data, the only output of the array
    rf_data_t rdata_q;

    // The array loses its contents while unpowered, so every entry is
    // forced to zero and all requests are dropped in that time
    always_ff @(posedge clk) begin
        if (!powered) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // A read samples the old contents, so a write shows up one cycle later
    // The memory reset only clears stale output data when no read is launched
    always_ff @(posedge clk) begin
        if (!powered) begin
            rdata_q <= '0;
        end else if (rd.en) begin
            rdata_q <= mem[rd.addr];
        end else if (rst) begin
            rdata_q <= '0;
        end
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

/* design/rf_pg_4x26.sv */
// Power-gated register file wrapper: power-good delay, memory reset sync and isolation clamp
`timescale 1ns/1ps
`default_nettype none

module rf_pg_4x26 #(
    parameter int WAKE_CYCLES = 3
) (
     input  logic             clk
    ,input  logic             rst
    ,input  rf_pkg::rf_wr_t   wr
    ,input  rf_pkg::rf_rd_t   rd
    ,output rf_pkg::rf_data_t rdata
    ,input  logic             isol_en
    ,input  logic             pwr_enable_b
    ,output logic             pwr_enable_b_out
);

    import rf_pkg::*;

    logic [WAKE_CYCLES-1:0] pwr_chain;
    logic [1:0]             rst_sync;
    logic                   mem_rst;
    rf_data_t               rdata_raw;

    // ------------------------------------------------------------
    // Power switch model
    // ------------------------------------------------------------

    // Switching off is seen at once, the whole chain loads ones
    // Switching on shifts zeros in, so power good lags by WAKE_CYCLES
    always_ff @(posedge clk) begin
        if (rst) begin
            pwr_chain <= '0;
        end else if (pwr_enable_b) begin
            pwr_chain <= '1;
        end else begin
            pwr_chain <= pwr_chain << 1;
        end
    end

    // Active low power good, taken from the last stage
    assign pwr_enable_b_out = pwr_chain[WAKE_CYCLES-1];

    // ------------------------------------------------------------
    // Memory reset synchronizer
    // ------------------------------------------------------------

    // Held in reset while the array is unpowered, released two edges later
    always_ff @(posedge clk) begin
        if (rst || pwr_enable_b_out) begin
            rst_sync <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], 1'b0};
        end
    end

    assign mem_rst = rst_sync[1];

    rf_array_4x26 u_array (
         .clk     (clk)
        ,.rst     (mem_rst)
        ,.wr      (wr)
        ,.rd      (rd)
        ,.powered (!pwr_enable_b_out)
        ,.rdata   (rdata_raw)
    );

    // Isolation clamps the read data so nothing floats out of the off domain
    assign rdata = isol_en ? '0 : rdata_raw;

endmodule

`default_nettype wire

/* design/rf_pwr_ctrl.sv */
// Power controller that watches queue idleness and sequences isolation, power-off and wake
`timescale 1ns/1ps
`default_nettype none

module rf_pwr_ctrl #(
    parameter int IDLE_CYCLES = 8
) (
     input  logic               clk
    ,input  logic               rst
    ,input  logic               empty
    ,input  logic               push_valid
    ,input  logic               pwr_enable_b_out
    ,output logic               isol_en
    ,output logic               pwr_enable_b
    ,output logic               pwr_on
    ,output rf_pkg::pwr_state_t pwr_state
);

    import rf_pkg::*;

    // Counter holds up to IDLE_CYCLES-1 before the state leaves ON
    localparam int CNT_W = $clog2(IDLE_CYCLES + 1);

    pwr_state_t       state;
    pwr_state_t       state_nxt;
    logic [CNT_W-1:0] idle_cnt;
    logic             idle;

    // A cycle counts as idle only in ON with nothing stored and nothing offered
    assign idle = (state == PWR_ON) && empty && !push_valid;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            PWR_ON: begin
                // Leave on the edge that ends the IDLE_CYCLES-th idle cycle
                if (idle && idle_cnt == CNT_W'(IDLE_CYCLES - 1)) begin
                    state_nxt = PWR_ISOLATE;
                end
            end
            PWR_ISOLATE: begin
                // Outputs are clamped for one cycle before the switch opens
                state_nxt = PWR_OFF;
            end
            PWR_OFF: begin
                if (push_valid) begin
                    state_nxt = PWR_WAKE;
                end
            end
            PWR_WAKE: begin
                // Wait for the switch to report power good
                if (!pwr_enable_b_out) begin
                    state_nxt = PWR_ON;
                end
            end
            default: begin
                state_nxt = PWR_ON;
            end
        endcase
    end

    // ------------------------------------------------------------
    // State and idle counter
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= PWR_ON;
            idle_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Any busy cycle, or the move to ISOLATE, starts the count again
            if (idle && state_nxt == PWR_ON) begin
                idle_cnt <= idle_cnt + 1'b1;
            end else begin
                idle_cnt <= '0;
            end
        end
    end

    // Isolation stays on from ISOLATE until the cycle the state returns to ON
    assign isol_en      = (state != PWR_ON);
    assign pwr_enable_b = (state == PWR_OFF);
    assign pwr_on       = (state == PWR_ON);
    assign pwr_state    = state;

endmodule

`default_nettype wire

/* design/rf_queue_ctrl.sv */
// FIFO control over the register file: pointers, occupancy, push/pop handshakes and pop register
`timescale 1ns/1ps
`default_nettype none

module rf_queue_ctrl (
     input  logic             clk
    ,input  logic             rst
    ,input  logic             push_valid
    ,input  rf_pkg::rf_data_t push_data
    ,output logic             push_ready
    ,output logic             pop_valid
    ,output rf_pkg::rf_data_t pop_data
    ,input  logic             pop_ready
    ,input  logic             pwr_on
    ,output logic             empty
    ,output rf_pkg::rf_wr_t   wr
    ,output rf_pkg::rf_rd_t   rd
    ,input  rf_pkg::rf_data_t rdata
);

    import rf_pkg::*;

    // Wide enough for the full capacity of array plus pop register
    localparam int CNT_W = $clog2(RF_DEPTH + 2);

    logic [RF_ADDR_W-1:0] wr_ptr;
    logic [RF_ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]     arr_cnt;
    logic [CNT_W-1:0]     occ;
    logic                 inflight;
    logic                 out_valid;
    rf_data_t             out_data;
    logic                 push_fire;
    logic                 pop_fire;
    logic                 rd_issue;

    // ------------------------------------------------------------
    // Handshakes and occupancy
    // ------------------------------------------------------------

    assign push_fire = push_valid && push_ready;
    assign pop_fire  = out_valid && pop_ready;

    // Entries not yet read from the array, plus the one in flight or on the pop port
    assign occ = arr_cnt + CNT_W'(inflight) + CNT_W'(out_valid);

    // Capacity is RF_DEPTH plus the pop register, and pushes need full power
    assign push_ready = pwr_on && (occ < CNT_W'(RF_DEPTH + 1));
    assign empty      = (occ == '0);

    // Launch a read only when the pop register is free after this edge,
    // so the returning data always has a place to land
    assign rd_issue = (arr_cnt != '0) && !inflight && (!out_valid || pop_ready);

    // ------------------------------------------------------------
    // Register file requests
    // ------------------------------------------------------------

    assign wr.en   = push_fire;
    assign wr.addr = wr_ptr;
    assign wr.data = push_data;

    assign rd.en   = rd_issue;
    assign rd.addr = rd_ptr;

    // Pointers wrap on their own because RF_DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            arr_cnt  <= '0;
            inflight <= 1'b0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            arr_cnt  <= arr_cnt + CNT_W'(push_fire) - CNT_W'(rd_issue);
            // Read data comes back on the cycle after the request
            inflight <= rd_issue;
        end
    end

    // ------------------------------------------------------------
    // Pop register
    // ------------------------------------------------------------

    // Data in flight always finds the register empty, see rd_issue
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (inflight) begin
            out_valid <= 1'b1;
        end else if (pop_fire) begin
            out_valid <= 1'b0;
        end
    end

    // Payload holds its value until the next entry lands
    always_ff @(posedge clk) begin
        if (inflight) begin
            out_data <= rdata;
        end
    end

    assign pop_valid = out_valid;
    assign pop_data  = out_data;

endmodule

`default_nettype wire

/* design/rf_pg_queue_top.sv */
// Top level of the power-gated holding queue, wiring the FIFO control, power control and array
`timescale 1ns/1ps
`default_nettype none

module rf_pg_queue_top #(
    parameter int IDLE_CYCLES = 8,
    parameter int WAKE_CYCLES = 3
) (
     input  logic               clk
    ,input  logic               rst
    ,input  logic               push_valid
    ,input  rf_pkg::rf_data_t   push_data
    ,output logic               push_ready
    ,output logic               pop_valid
    ,output rf_pkg::rf_data_t   pop_data
    ,input  logic               pop_ready
    ,output rf_pkg::pwr_state_t pwr_state
);

    import rf_pkg::*;

    // Queue side of the array
    rf_wr_t   wr;
    rf_rd_t   rd;
    rf_data_t rdata;

    // Power handshake between controller and array
    logic empty;
    logic pwr_on;
    logic isol_en;
    logic pwr_enable_b;
    logic pwr_enable_b_out;

    rf_queue_ctrl u_queue_ctrl (
         .clk        (clk)
        ,.rst        (rst)
        ,.push_valid (push_valid)
        ,.push_data  (push_data)
        ,.push_ready (push_ready)
        ,.pop_valid  (pop_valid)
        ,.pop_data   (pop_data)
        ,.pop_ready  (pop_ready)
        ,.pwr_on     (pwr_on)
        ,.empty      (empty)
        ,.wr         (wr)
        ,.rd         (rd)
        ,.rdata      (rdata)
    );

    rf_pwr_ctrl #(
        .IDLE_CYCLES (IDLE_CYCLES)
    ) u_pwr_ctrl (
         .clk              (clk)
        ,.rst              (rst)
        ,.empty            (empty)
        ,.push_valid       (push_valid)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pwr_on           (pwr_on)
        ,.pwr_state        (pwr_state)
    );

    rf_pg_4x26 #(
        .WAKE_CYCLES (WAKE_CYCLES)
    ) u_rf (
         .clk              (clk)
        ,.rst              (rst)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

`default_nettype wire

/* dv/rf_pg_queue_tb.sv */
// Self-checking testbench for the power-gated queue that runs as the simulation top over the RTL
`timescale 1ns/1ps
`default_nettype none

module rf_pg_queue_tb;

    import rf_pkg::*;

    localparam int IDLE_CYCLES = 8;
    localparam int WAKE_CYCLES = 3;
    // Array entries plus the pop output register
    localparam int CAPACITY    = RF_DEPTH + 1;

    logic       clk;
    logic       rst;
    logic       push_valid;
    rf_data_t   push_data;
    logic       push_ready;
    logic       pop_valid;
    rf_data_t   pop_data;
    logic       pop_ready;
    pwr_state_t pwr_state;

    // Reference model state that is updated on every rising edge
    rf_data_t   model_q [$];
    int         exp_count;
    rf_data_t   exp_front;
    pwr_state_t exp_state;
    int         idle_run;
    int         wake_run;

    // Previous-cycle copies used by the hold and reset checks
    logic       rst_q;
    logic       pop_wait_q;
    rf_data_t   pop_data_q;

    logic       push_took;
    logic [31:0] rng;
    string      test_name;

    rf_pg_queue_top #(
        .IDLE_CYCLES (IDLE_CYCLES),
        .WAKE_CYCLES (WAKE_CYCLES)
    ) u_rf_pg_queue_top (
         .clk        (clk)
        ,.rst        (rst)
        ,.push_valid (push_valid)
        ,.push_data  (push_data)
        ,.push_ready (push_ready)
        ,.pop_valid  (pop_valid)
        ,.pop_data   (pop_data)
        ,.pop_ready  (pop_ready)
        ,.pwr_state  (pwr_state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic report_fail(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("ERR %s (%s): expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout in %s: %s", test_name, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Plain LCG whose upper bits are the usable ones
    function automatic logic [31:0] rand_word();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Advance one cycle
    // push_took tells whether the push handshake fired on that edge
    task automatic step();
        @(negedge clk);
        push_took = push_valid && push_ready;
        @(posedge clk);
        #1;
    endtask

    function automatic rf_data_t new_data();
        logic [31:0] r;
        r = rand_word();
        return r[31:6];
    endfunction

    // A pending push may not be withdrawn, so hold it until it is taken
    task automatic finish_push();
        int n;
        n = 0;
        pop_ready = 1'b1;
        while (push_valid && !push_took) begin
            if (n > 50) timeout_fail("pending push never accepted");
            n++;
            step();
        end
        push_valid = 1'b0;
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        pop_ready = 1'b1;
        while (exp_count != 0) begin
            if (n > 100) timeout_fail("queue did not drain");
            n++;
            step();
        end
    endtask

    task automatic run_random(input int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            r = rand_word();
            if (!push_valid || push_took) begin
                push_valid = (r[31:30] != 2'b00);
                push_data  = new_data();
            end
            pop_ready = r[29];
            step();
        end
        finish_push();
        drain_queue();
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            model_q.delete();
            exp_count <= 0;
            exp_front <= '0;
        end else begin
            if (pop_valid && pop_ready && model_q.size() > 0) begin
                void'(model_q.pop_front());
            end
            if (push_valid && push_ready) begin
                model_q.push_back(push_data);
            end
            exp_count <= model_q.size();
            exp_front <= (model_q.size() > 0) ? model_q[0] : '0;
        end
    end

    // Expected power sequence of the controller
    always @(posedge clk) begin
        if (rst) begin
            exp_state <= PWR_ON;
            idle_run  <= 0;
            wake_run  <= 0;
        end else begin
            case (exp_state)
                PWR_ON: begin
                    if (exp_count == 0 && !push_valid) begin
                        if (idle_run == IDLE_CYCLES - 1) begin
                            exp_state <= PWR_ISOLATE;
                            idle_run  <= 0;
                        end else begin
                            idle_run <= idle_run + 1;
                        end
                    end else begin
                        idle_run <= 0;
                    end
                end
                PWR_ISOLATE: exp_state <= PWR_OFF;
                PWR_OFF: begin
                    if (push_valid) begin
                        exp_state <= PWR_WAKE;
                        wake_run  <= 0;
                    end
                end
                default: begin
                    // WAKE lasts WAKE_CYCLES+1 cycles and push_ready follows one cycle later
                    if (wake_run == WAKE_CYCLES) begin
                        exp_state <= PWR_ON;
                    end else begin
                        wake_run <= wake_run + 1;
                    end
                end
            endcase
        end
    end

    always @(posedge clk) begin
        rst_q      <= rst;
        pop_wait_q <= !rst && pop_valid && !pop_ready;
        pop_data_q <= pop_data;
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    a_pop_order: assert property (@(posedge clk) disable iff (rst)
        (pop_valid && pop_ready) |-> (pop_data == exp_front))
        else report_fail("pop order", 32'($sampled(exp_front)), 32'($sampled(pop_data)));

    a_no_stale: assert property (@(posedge clk) disable iff (rst)
        pop_valid |-> (exp_count != 0))
        else report_fail("pop_valid with empty model", 32'd0, 32'd1);

    a_pop_valid_hold: assert property (@(posedge clk) disable iff (rst)
        pop_wait_q |-> pop_valid)
        else report_fail("pop_valid dropped before pop", 32'd1, 32'($sampled(pop_valid)));

    a_pop_data_hold: assert property (@(posedge clk) disable iff (rst)
        pop_wait_q |-> (pop_data == pop_data_q))
        else report_fail("pop_data changed while waiting", 32'($sampled(pop_data_q)),
                         32'($sampled(pop_data)));

    a_push_ready: assert property (@(posedge clk) disable iff (rst)
        push_ready == ((exp_state == PWR_ON) && (exp_count < CAPACITY)))
        else report_fail("push_ready",
                         32'(($sampled(exp_state) == PWR_ON) && ($sampled(exp_count) < CAPACITY)),
                         32'($sampled(push_ready)));

    a_pwr_state: assert property (@(posedge clk) disable iff (rst)
        pwr_state == exp_state)
        else report_fail("pwr_state", 32'($sampled(exp_state)), 32'($sampled(pwr_state)));

    // A queue holding entries must keep its array powered
    a_busy_on: assert property (@(posedge clk) disable iff (rst)
        (exp_count != 0) |-> (pwr_state == PWR_ON))
        else report_fail("power left ON while busy", 32'(PWR_ON), 32'($sampled(pwr_state)));

    // Packed as {push_ready, pop_valid, pwr_state}
    a_reset_state: assert property (@(posedge clk)
        (rst_q && !rst) |-> (push_ready && !pop_valid && pwr_state == PWR_ON))
        else report_fail("state after reset", 32'h8,
                         32'({$sampled(push_ready), $sampled(pop_valid), $sampled(pwr_state)}));

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        int waited;
        rst        = 1'b1;
        push_valid = 1'b0;
        push_data  = '0;
        pop_ready  = 1'b0;
        push_took  = 1'b0;
        rng        = 32'hfbae3c26;
        test_name  = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        step();

        test_name = "order";
        run_random(200);

        // Fill to capacity, then hold one more push against a stalled pop port
        test_name = "backpressure";
        pop_ready = 1'b0;
        for (int k = 0; k < CAPACITY; k++) begin
            push_valid = 1'b1;
            push_data  = new_data();
            waited     = 0;
            step();
            while (!push_took) begin
                if (waited > 20) timeout_fail("push below capacity not accepted");
                waited++;
                step();
            end
        end
        push_data = new_data();
        for (int k = 0; k < 4 * IDLE_CYCLES; k++) begin
            step();
            assert (!push_took) else report_fail("push beyond capacity", 32'd0, 32'd1);
        end
        assert (pop_valid)
            else report_fail("pop_valid while full", 32'd1, 32'(pop_valid));
        finish_push();
        drain_queue();

        test_name = "power_down";
        waited = 0;
        while (pwr_state != PWR_OFF) begin
            if (waited > 4 * IDLE_CYCLES) timeout_fail("array never powered down");
            waited++;
            step();
        end

        // Push in OFF waits WAKE_CYCLES+2 cycles with push_ready low
        test_name  = "wake";
        pop_ready  = 1'b0;
        push_valid = 1'b1;
        push_data  = new_data();
        waited     = 0;
        step();
        while (!push_took) begin
            if (waited > 4 * WAKE_CYCLES + 8) timeout_fail("wake push never accepted");
            waited++;
            step();
        end
        push_valid = 1'b0;
        assert (waited == WAKE_CYCLES + 2)
            else report_fail("wake latency", 32'(WAKE_CYCLES + 2), 32'(waited));
        drain_queue();

        test_name = "order_after_wake";
        run_random(120);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/rf_pkg.sv
design/rf_array_4x26.sv
design/rf_pg_4x26.sv
design/rf_pwr_ctrl.sv
design/rf_queue_ctrl.sv
design/rf_pg_queue_top.sv
dv/rf_pg_queue_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the power-gated queue testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module rf_pg_queue_tb -o rf_pg_queue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rf_pg_queue_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
